// File: bench/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int HALF_PERIOD = 50,
  parameter int OFFSET      = 0
) (
  output logic clk_o
);

  // Free running, phase set by the start offset
  initial begin
    clk_o = 1'b0;
    #(OFFSET);
    forever begin
      #(HALF_PERIOD);
      clk_o = ~clk_o;
    end
  end

endmodule

`default_nettype wire

// File: bench/tb_wb_dts_attach.sv
`timescale 1ns/1ps
`default_nettype none

`include "dts_attach_consts.svh"

module tb_wb_dts_attach;

  import dts_regmap_pkg::*;
  import dts_status_pkg::*;

  localparam int NUM_TESTS     = 5;
  localparam int RESET_CYCLES  = 10;
  localparam int SETTLE_CYCLES = 20;
  localparam int ACK_WAIT      = 4;
  localparam int PAD           = 32 - `DTS_NUM_CH;

  logic                   wb_clk_i;
  logic                   user_clk;
  logic                   wb_rst_i;
  logic [31:0]            wb_adr_i;
  logic [3:0]             wb_sel_i;
  logic [31:0]            wb_dat_i;
  logic                   wb_we_i;
  logic                   wb_cyc_i;
  logic                   wb_stb_i;
  logic [7:0]             def_data_i;
  logic [`DTS_NUM_CH-1:0] def_locked_i;
  logic [`DTS_NUM_CH-1:0] gt_locked_i;
  wire  [31:0]            wb_dat_o;
  wire                    wb_ack_o;
  wire                    wb_err_o;
  wire  [7:0]             def_data_o;
  wire  [7:0]             def_addr_o;
  wire  [`DTS_NUM_CH-1:0] cs_o;
  wire                    wrst_o;
  wire                    rdst_o;
  wire                    unmute_o;
  wire  [`DTS_NUM_CH-1:0] shift_advance_o;
  wire  [`DTS_NUM_CH-1:0] shift_delay_o;
  wire                    shift_rst_o;
  wire  [`DTS_MUX_W-1:0]  mux_control_o;
  wire                    is_three_bit_o;
  wire  [`DTS_NUM_CH-1:0] induce_error_o;

  int          check_cnt    = 0;
  int          mismatch_cnt = 0;
  int          bus_err_cnt  = 0;
  logic [31:0] lcg_state    = 32'd54093;
  // Expected readback of offsets 1 to 5
  logic [31:0] exp_regs [1:5];

  //////////////////////////////////////////////////////////////////////
  // Clocks and DUT
  //////////////////////////////////////////////////////////////////////

  tb_clock_gen #(.HALF_PERIOD(50), .OFFSET(0))  u_wb_clk   (.clk_o(wb_clk_i));
  tb_clock_gen #(.HALF_PERIOD(50), .OFFSET(37)) u_user_clk (.clk_o(user_clk));

  wb_dts_attach i_wb_dts_attach (
    .wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i), .wb_adr_i(wb_adr_i), .wb_sel_i(wb_sel_i),
    .wb_dat_i(wb_dat_i), .wb_we_i(wb_we_i), .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i),
    .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o), .wb_err_o(wb_err_o), .user_clk(user_clk),
    .def_data_i(def_data_i), .def_data_o(def_data_o), .def_addr_o(def_addr_o),
    .cs_o(cs_o), .wrst_o(wrst_o), .rdst_o(rdst_o), .unmute_o(unmute_o),
    .shift_advance_o(shift_advance_o), .shift_delay_o(shift_delay_o),
    .shift_rst_o(shift_rst_o), .mux_control_o(mux_control_o),
    .is_three_bit_o(is_three_bit_o), .induce_error_o(induce_error_o),
    .def_locked_i(def_locked_i), .gt_locked_i(gt_locked_i)
  );

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  // Numerical Recipes LCG
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Readback of a written word keeps only the implemented bits
  function automatic logic [31:0] implemented_bits(input int off, input logic [31:0] data);
    dts_delay_u dly;
    dly.raw     = data;
    dly.f.spare = '0;
    case (off)
      1:       return dly.raw;
      2:       return data;
      3:       return data & 32'h0000_ffff;
      4:       return data & 32'h0000_0001;
      5:       return data & {{PAD{1'b0}}, {`DTS_NUM_CH{1'b1}}};
      default: return 32'h0;
    endcase
  endfunction

  task automatic report_mismatch(input string what, input logic [47:0] got,
                                 input logic [47:0] exp);
    mismatch_cnt++;
    $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
  endtask

  task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
    check_cnt++;
    if (got !== exp) begin
      report_mismatch(what, got, exp);
    end
  endtask

  // Decoded deformatter controls against the control word fields
  task automatic check_ctrl(input dts_ctrl_u exp);
    check_cnt++;
    if (def_data_o !== exp.f.data) report_mismatch("ctrl data", def_data_o, exp.f.data);
    if (def_addr_o !== exp.f.addr) report_mismatch("ctrl addr", def_addr_o, exp.f.addr);
    if (cs_o !== exp.f.cs) report_mismatch("ctrl cs", cs_o, exp.f.cs);
    if (wrst_o !== exp.f.wrst) report_mismatch("ctrl wrst", wrst_o, exp.f.wrst);
    if (rdst_o !== exp.f.rdst) report_mismatch("ctrl rdst", rdst_o, exp.f.rdst);
    if (unmute_o !== exp.f.unmute) report_mismatch("ctrl unmute", unmute_o, exp.f.unmute);
  endtask

  task automatic check_status(input dts_status_u got, input dts_status_u exp);
    check_cnt++;
    if (got.f.gt_locked !== exp.f.gt_locked)
      report_mismatch("status gt_locked", got.f.gt_locked, exp.f.gt_locked);
    if (got.f.def_locked !== exp.f.def_locked)
      report_mismatch("status def_locked", got.f.def_locked, exp.f.def_locked);
    if (got.f.rd_data !== exp.f.rd_data)
      report_mismatch("status rd_data", got.f.rd_data, exp.f.rd_data);
  endtask

  // Quasi-static outputs follow the register words
  task automatic compare_static_outputs();
    dts_delay_u dly;
    dly.raw = exp_regs[1];
    check_word("shift_advance_o", {{PAD{1'b0}}, shift_advance_o}, {{PAD{1'b0}}, dly.f.advance});
    check_word("shift_delay_o", {{PAD{1'b0}}, shift_delay_o}, {{PAD{1'b0}}, dly.f.delay});
    check_word("shift_rst_o", {31'b0, shift_rst_o}, {31'b0, dly.f.shift_rst});
    check_word("mux_control_o low", mux_control_o[31:0], exp_regs[2]);
    check_word("mux_control_o high", {16'b0, mux_control_o[47:32]}, exp_regs[3]);
    check_word("is_three_bit_o", {31'b0, is_three_bit_o}, exp_regs[4]);
    check_word("induce_error_o", {{PAD{1'b0}}, induce_error_o}, exp_regs[5]);
  endtask

  task automatic settle();
    repeat (SETTLE_CYCLES) @(posedge wb_clk_i);
    #1;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Bus cycles
  //////////////////////////////////////////////////////////////////////

  // One classic cycle with ack sampled 1 ns after the edge
  task automatic bus_access(input logic [3:0] off, input logic we, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    int   waited;
    logic got_ack;
    @(posedge wb_clk_i);
    #5;
    wb_adr_i = {26'b0, off, 2'b00};
    wb_dat_i = wdata;
    wb_we_i  = we;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    got_ack  = 1'b0;
    waited   = 0;
    rdata    = '0;
    while (!got_ack && waited < ACK_WAIT) begin
      @(posedge wb_clk_i);
      #1;
      waited++;
      if (wb_ack_o === 1'b1) begin
        got_ack = 1'b1;
        rdata   = wb_dat_o;
        if (wb_err_o !== 1'b0) begin
          bus_err_cnt++;
          $display("error at %0t: wb_err_o raised on offset %0d", $time, off);
        end
      end
    end
    if (!got_ack) begin
      bus_err_cnt++;
      $display("error at %0t: ack missing for offset %0d after %0d cycles", $time, off, ACK_WAIT);
    end
    #4;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    // Exactly one ack cycle
    @(posedge wb_clk_i);
    #1;
    if (wb_ack_o !== 1'b0) begin
      bus_err_cnt++;
      $display("error at %0t: ack stayed high for more than one cycle", $time);
    end
  endtask

  task automatic wb_write(input logic [3:0] off, input logic [31:0] data);
    logic [31:0] unused;
    bus_access(off, 1'b1, data, unused);
  endtask

  task automatic wb_read(input logic [3:0] off, output logic [31:0] data);
    bus_access(off, 1'b0, 32'h0, data);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic reset_defaults();
    logic [31:0] rd;
    dts_ctrl_u   zero_ctrl;
    zero_ctrl.raw = '0;
    check_ctrl(zero_ctrl);
    check_word("wb_ack_o after reset", {31'b0, wb_ack_o}, 32'h0);
    compare_static_outputs();
    for (int off = 1; off <= 5; off++) begin
      wb_read(off[3:0], rd);
      check_word($sformatf("reset read offset %0d", off), rd, 32'h0);
    end
  endtask

  task automatic register_readback();
    logic [31:0] rd;
    logic [31:0] data;
    for (int off = 1; off <= 5; off++) begin
      data = next_rand();
      wb_write(off[3:0], data);
      exp_regs[off] = implemented_bits(off, data);
      wb_read(off[3:0], rd);
      check_word($sformatf("readback offset %0d", off), rd, exp_regs[off]);
    end
    compare_static_outputs();
  endtask

  task automatic control_crossing();
    dts_ctrl_u first;
    dts_ctrl_u second;
    for (int i = 0; i < 3; i++) begin
      first.raw = next_rand();
      wb_write(`DTS_REG_CTRL, first.raw);
      settle();
      check_ctrl(first);
    end
    // Back to back writes leave the later word
    first.raw  = next_rand();
    second.raw = next_rand();
    wb_write(`DTS_REG_CTRL, first.raw);
    wb_write(`DTS_REG_CTRL, second.raw);
    settle();
    check_ctrl(second);
  endtask

  task automatic status_crossing();
    logic [31:0] rd;
    dts_status_u exp;
    dts_status_u got;
    for (int i = 0; i < 4; i++) begin
      @(posedge wb_clk_i);
      #5;
      exp.raw      = next_rand();
      gt_locked_i  = exp.f.gt_locked;
      def_locked_i = exp.f.def_locked;
      def_data_i   = exp.f.rd_data;
      settle();
      wb_read(`DTS_REG_CTRL, rd);
      got.raw = rd;
      check_status(got, exp);
    end
  endtask

  task automatic unmapped_offsets();
    logic [31:0] rd;
    for (int off = 6; off <= 15; off++) begin
      wb_read(off[3:0], rd);
      check_word($sformatf("unmapped read offset %0d", off), rd, 32'h0);
      wb_write(off[3:0], next_rand());
    end
    // Mapped words untouched
    for (int off = 1; off <= 5; off++) begin
      wb_read(off[3:0], rd);
      check_word($sformatf("readback after unmapped offset %0d", off), rd, exp_regs[off]);
    end
    compare_static_outputs();
  endtask

  //////////////////////////////////////////////////////////////////////
  // Run control
  //////////////////////////////////////////////////////////////////////

  initial begin
    wb_rst_i     = 1'b1;
    wb_adr_i     = '0;
    wb_sel_i     = 4'hf;
    wb_dat_i     = '0;
    wb_we_i      = 1'b0;
    wb_cyc_i     = 1'b0;
    wb_stb_i     = 1'b0;
    def_data_i   = '0;
    def_locked_i = '0;
    gt_locked_i  = '0;
    for (int k = 1; k <= 5; k++) begin
      exp_regs[k] = 32'h0;
    end
    repeat (RESET_CYCLES) @(posedge wb_clk_i);
    #5;
    wb_rst_i = 1'b0;
    reset_defaults();
    register_readback();
    control_crossing();
    status_crossing();
    unmapped_offsets();
    $display("Summary: %0d checks, %0d mismatches, %0d bus errors",
             check_cnt, mismatch_cnt, bus_err_cnt);
    if (mismatch_cnt == 0 && bus_err_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // Watchdog allows 400 bus cycles per test
  initial begin
    repeat (NUM_TESTS * 400) @(posedge wb_clk_i);
    $display("error at %0t: run did not finish within %0d cycles", $time, NUM_TESTS * 400);
    $display("Summary: %0d checks, %0d mismatches, %0d bus errors",
             check_cnt, mismatch_cnt, bus_err_cnt);
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: design/dts_ctrl_cdc.sv
`timescale 1ns/1ps
`default_nettype none

`include "dts_attach_consts.svh"

module dts_ctrl_cdc (
  input  wire                        wb_clk_i,
  input  wire                        user_clk,
  input  wire                        wb_rst_i,
  input  dts_regmap_pkg::dts_ctrl_u  ctrl_word_i,
  input  wire                        ctrl_ready_i,
  output logic                       ctrl_done_o,
  output logic [7:0]                 def_data_o,
  output logic [7:0]                 def_addr_o,
  output logic [`DTS_NUM_CH-1:0]     cs_o,
  output logic                       wrst_o,
  output logic                       rdst_o,
  output logic                       unmute_o
);

  import dts_regmap_pkg::*;

  localparam int N = `DTS_SYNC_STAGES;

  logic [N-1:0] rst_pipe;
  logic         user_rst;
  logic [N-1:0] ready_sync;
  logic         done_q;
  logic [N-1:0] done_sync;
  dts_ctrl_u    ctrl_q;

  //////////////////////////////////////////////////////////////////////
  // User clock side
  //////////////////////////////////////////////////////////////////////

  // Bus reset into user_clk
  always_ff @(posedge user_clk) begin
    rst_pipe <= {rst_pipe[N-2:0], wb_rst_i};
  end

  assign user_rst = rst_pipe[N-1];

  always_ff @(posedge user_clk) begin
    if (user_rst) begin
      ready_sync <= '0;
      done_q     <= 1'b0;
      ctrl_q     <= '0;
    end else begin
      ready_sync <= {ready_sync[N-2:0], ctrl_ready_i};
      // Done mirrors the synchronized ready
      done_q <= ready_sync[N-1];
      // Re-copy while ready is up, latest write wins
      if (ready_sync[N-1]) begin
        ctrl_q <= ctrl_word_i;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Bus clock side
  //////////////////////////////////////////////////////////////////////

  // Done back into wb_clk_i
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      done_sync <= '0;
    end else begin
      done_sync <= {done_sync[N-2:0], done_q};
    end
  end

  assign ctrl_done_o = done_sync[N-1];

  // Deformatter control fields
  assign def_data_o = ctrl_q.f.data;
  assign def_addr_o = ctrl_q.f.addr;
  assign cs_o       = ctrl_q.f.cs;
  assign wrst_o     = ctrl_q.f.wrst;
  assign rdst_o     = ctrl_q.f.rdst;
  assign unmute_o   = ctrl_q.f.unmute;

endmodule

`default_nettype wire

// File: design/dts_regmap_pkg.sv
`default_nettype none

`include "dts_attach_consts.svh"

package dts_regmap_pkg;

  // Control word fields, data in the low byte
  typedef struct packed {
    logic                   spare;
    logic [`DTS_NUM_CH-1:0] cs;
    logic                   unmute;
    logic                   rdst;
    logic                   wrst;
    logic [7:0]             addr;
    logic [7:0]             data;
  } dts_ctrl_f_t;

  // Control word, raw bus view or field view
  typedef union packed {
    logic [31:0] raw;
    dts_ctrl_f_t f;
  } dts_ctrl_u;

  // Delay control fields, shift reset in the top bit
  typedef struct packed {
    logic                   shift_rst;
    logic [6:0]             spare;
    logic [`DTS_NUM_CH-1:0] delay;
    logic [`DTS_NUM_CH-1:0] advance;
  } dts_delay_f_t;

  // Delay control, raw bus view or field view
  typedef union packed {
    logic [31:0]  raw;
    dts_delay_f_t f;
  } dts_delay_u;

endpackage

`default_nettype wire

// File: design/dts_status_cdc.sv
`timescale 1ns/1ps
`default_nettype none

`include "dts_attach_consts.svh"

module dts_status_cdc (
  input  wire                          wb_clk_i,
  input  wire                          user_clk,
  input  wire                          wb_rst_i,
  input  wire [7:0]                    def_data_i,
  input  wire [`DTS_NUM_CH-1:0]        def_locked_i,
  input  wire [`DTS_NUM_CH-1:0]        gt_locked_i,
  output dts_status_pkg::dts_status_u  status_word_o
);

  import dts_status_pkg::*;

  localparam int N = `DTS_SYNC_STAGES;

  logic [N-1:0] rst_pipe;
  logic         user_rst;
  logic         req_q;
  logic [N-1:0] ready_sync;
  logic [N-1:0] req_sync;
  logic         ready_q;
  dts_status_u  buf_q;
  dts_status_u  status_q;

  //////////////////////////////////////////////////////////////////////
  // Bus clock side
  //////////////////////////////////////////////////////////////////////

  // Request while the buffer is not on offer
  // Dropped once the ready is seen
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      req_q      <= 1'b0;
      ready_sync <= '0;
    end else begin
      ready_sync <= {ready_sync[N-2:0], ready_q};
      req_q      <= !ready_sync[N-1];
    end
  end

  // Take the buffer while it is held for us
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      status_q <= '0;
    end else if (ready_sync[N-1] && req_q) begin
      status_q <= buf_q;
    end
  end

  assign status_word_o = status_q;

  //////////////////////////////////////////////////////////////////////
  // User clock side
  //////////////////////////////////////////////////////////////////////

  // Bus reset into user_clk
  always_ff @(posedge user_clk) begin
    rst_pipe <= {rst_pipe[N-2:0], wb_rst_i};
  end

  assign user_rst = rst_pipe[N-1];

  // Ready follows the synchronized request
  always_ff @(posedge user_clk) begin
    if (user_rst) begin
      req_sync <= '0;
      ready_q  <= 1'b0;
    end else begin
      req_sync <= {req_sync[N-2:0], req_q};
      ready_q  <= req_sync[N-1];
    end
  end

  // Snapshot only while the buffer is free
  always_ff @(posedge user_clk) begin
    if (user_rst) begin
      buf_q <= '0;
    end else if (req_sync[N-1] && !ready_q) begin
      buf_q.f.gt_locked  <= gt_locked_i;
      buf_q.f.def_locked <= def_locked_i;
      buf_q.f.rd_data    <= def_data_i;
    end
  end

endmodule

`default_nettype wire

// File: design/dts_status_pkg.sv
`default_nettype none

`include "dts_attach_consts.svh"

package dts_status_pkg;

  // Status snapshot fields, transceiver locks on top
  typedef struct packed {
    logic [`DTS_NUM_CH-1:0] gt_locked;
    logic [`DTS_NUM_CH-1:0] def_locked;
    logic [7:0]             rd_data;
  } dts_status_f_t;

  // Status snapshot, raw read word or field view
  typedef union packed {
    logic [31:0]   raw;
    dts_status_f_t f;
  } dts_status_u;

endpackage

`default_nettype wire

// File: design/wb_dts_attach.sv
`timescale 1ns/1ps
`default_nettype none

`include "dts_attach_consts.svh"

module wb_dts_attach (
  // Wishbone slave
  input  wire                     wb_clk_i,
  input  wire                     wb_rst_i,
  input  wire [31:0]              wb_adr_i,
  input  wire [3:0]               wb_sel_i,
  input  wire [31:0]              wb_dat_i,
  input  wire                     wb_we_i,
  input  wire                     wb_cyc_i,
  input  wire                     wb_stb_i,
  output wire [31:0]              wb_dat_o,
  output wire                     wb_ack_o,
  output wire                     wb_err_o,
  input  wire                     user_clk,
  // Deformatter control
  input  wire [7:0]               def_data_i,
  output wire [7:0]               def_data_o,
  output wire [7:0]               def_addr_o,
  output wire [`DTS_NUM_CH-1:0]   cs_o,
  output wire                     wrst_o,
  output wire                     rdst_o,
  output wire                     unmute_o,
  // Delay and mux
  output wire [`DTS_NUM_CH-1:0]   shift_advance_o,
  output wire [`DTS_NUM_CH-1:0]   shift_delay_o,
  output wire                     shift_rst_o,
  output wire [`DTS_MUX_W-1:0]    mux_control_o,
  output wire                     is_three_bit_o,
  // Error injection and status
  output wire [`DTS_NUM_CH-1:0]   induce_error_o,
  input  wire [`DTS_NUM_CH-1:0]   def_locked_i,
  input  wire [`DTS_NUM_CH-1:0]   gt_locked_i
);

  import dts_regmap_pkg::*;
  import dts_status_pkg::*;

  // Write crossing
  dts_ctrl_u   ctrl_word;
  logic        ctrl_ready;
  logic        ctrl_done;
  // Read crossing
  dts_status_u status_word;

  //////////////////////////////////////////////////////////////////////
  // Bus register file
  //////////////////////////////////////////////////////////////////////

  wb_dts_regs u_regs (
    .wb_clk_i        (wb_clk_i),
    .wb_rst_i        (wb_rst_i),
    .wb_adr_i        (wb_adr_i),
    .wb_sel_i        (wb_sel_i),
    .wb_dat_i        (wb_dat_i),
    .wb_we_i         (wb_we_i),
    .wb_cyc_i        (wb_cyc_i),
    .wb_stb_i        (wb_stb_i),
    .wb_dat_o        (wb_dat_o),
    .wb_ack_o        (wb_ack_o),
    .wb_err_o        (wb_err_o),
    .status_word_i   (status_word),
    .ctrl_done_i     (ctrl_done),
    .ctrl_word_o     (ctrl_word),
    .ctrl_ready_o    (ctrl_ready),
    .shift_advance_o (shift_advance_o),
    .shift_delay_o   (shift_delay_o),
    .shift_rst_o     (shift_rst_o),
    .mux_control_o   (mux_control_o),
    .is_three_bit_o  (is_three_bit_o),
    .induce_error_o  (induce_error_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Clock crossings
  //////////////////////////////////////////////////////////////////////

  // Control word into user_clk
  dts_ctrl_cdc u_ctrl_cdc (
    .wb_clk_i     (wb_clk_i),
    .user_clk     (user_clk),
    .wb_rst_i     (wb_rst_i),
    .ctrl_word_i  (ctrl_word),
    .ctrl_ready_i (ctrl_ready),
    .ctrl_done_o  (ctrl_done),
    .def_data_o   (def_data_o),
    .def_addr_o   (def_addr_o),
    .cs_o         (cs_o),
    .wrst_o       (wrst_o),
    .rdst_o       (rdst_o),
    .unmute_o     (unmute_o)
  );

  // Status snapshot back to the bus
  dts_status_cdc u_status_cdc (
    .wb_clk_i      (wb_clk_i),
    .user_clk      (user_clk),
    .wb_rst_i      (wb_rst_i),
    .def_data_i    (def_data_i),
    .def_locked_i  (def_locked_i),
    .gt_locked_i   (gt_locked_i),
    .status_word_o (status_word)
  );

endmodule

`default_nettype wire

// File: design/wb_dts_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "dts_attach_consts.svh"

module wb_dts_regs (
  input  wire                          wb_clk_i,
  input  wire                          wb_rst_i,
  input  wire [31:0]                   wb_adr_i,
  input  wire [3:0]                    wb_sel_i,
  input  wire [31:0]                   wb_dat_i,
  input  wire                          wb_we_i,
  input  wire                          wb_cyc_i,
  input  wire                          wb_stb_i,
  output logic [31:0]                  wb_dat_o,
  output logic                         wb_ack_o,
  output logic                         wb_err_o,
  input  dts_status_pkg::dts_status_u  status_word_i,
  input  wire                          ctrl_done_i,
  output dts_regmap_pkg::dts_ctrl_u    ctrl_word_o,
  output logic                         ctrl_ready_o,
  output logic [`DTS_NUM_CH-1:0]       shift_advance_o,
  output logic [`DTS_NUM_CH-1:0]       shift_delay_o,
  output logic                         shift_rst_o,
  output logic [`DTS_MUX_W-1:0]        mux_control_o,
  output logic                         is_three_bit_o,
  output logic [`DTS_NUM_CH-1:0]       induce_error_o
);

  import dts_regmap_pkg::*;

  localparam int ADR_W    = `DTS_ADR_MSB - `DTS_ADR_LSB + 1;
  localparam int MUX_HI_W = `DTS_MUX_W - 32;

  logic [ADR_W-1:0]       reg_sel;
  logic                   bus_req;
  logic                   ack_q;
  logic [31:0]            rdata_q;
  logic [31:0]            rd_mux;
  logic                   ready_q;
  dts_ctrl_u              ctrl_q;
  dts_delay_u             delay_q;
  dts_delay_u             wdata_delay;
  logic [`DTS_MUX_W-1:0]  mux_q;
  logic                   three_bit_q;
  logic [`DTS_NUM_CH-1:0] err_q;

  //////////////////////////////////////////////////////////////////////
  // Bus decode
  //////////////////////////////////////////////////////////////////////

  // Word select from the byte address
  // Upper address bits ignored
  assign reg_sel = wb_adr_i[`DTS_ADR_MSB:`DTS_ADR_LSB];

  // New cycle only while no ack is out
  // A held strobe gets an ack every second clock
  // wb_sel_i has no effect on writes
  assign bus_req = wb_cyc_i && wb_stb_i && !ack_q;

  // Field view of incoming write data
  assign wdata_delay.raw = wb_dat_i;

  //////////////////////////////////////////////////////////////////////
  // Register file
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      ack_q       <= 1'b0;
      ready_q     <= 1'b0;
      ctrl_q      <= '0;
      delay_q     <= '0;
      mux_q       <= '0;
      three_bit_q <= 1'b0;
      err_q       <= '0;
    end else begin
      // Single cycle ack
      ack_q <= bus_req;
      if (bus_req && wb_we_i) begin
        case (reg_sel)
          `DTS_REG_CTRL: ctrl_q.raw <= wb_dat_i;
          `DTS_REG_DELAY: begin
            // Spare bits stay zero
            delay_q.f.advance   <= wdata_delay.f.advance;
            delay_q.f.delay     <= wdata_delay.f.delay;
            delay_q.f.shift_rst <= wdata_delay.f.shift_rst;
          end
          `DTS_REG_MUX_LO: mux_q[31:0] <= wb_dat_i;
          `DTS_REG_MUX_HI: mux_q[`DTS_MUX_W-1:32] <= wb_dat_i[MUX_HI_W-1:0];
          `DTS_REG_THREE_BIT: three_bit_q <= wb_dat_i[0];
          `DTS_REG_ERR: err_q <= wb_dat_i[`DTS_NUM_CH-1:0];
          default: ;
        endcase
      end
      // Any write raises ready
      // A new write wins over a stale done
      if (bus_req && wb_we_i) begin
        ready_q <= 1'b1;
      end else if (ctrl_done_i) begin
        ready_q <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read path
  //////////////////////////////////////////////////////////////////////

  // Offset 0 returns the status snapshot and not the control word
  always_comb begin
    rd_mux = '0;
    case (reg_sel)
      `DTS_REG_CTRL:      rd_mux = status_word_i.raw;
      `DTS_REG_DELAY:     rd_mux = delay_q.raw;
      `DTS_REG_MUX_LO:    rd_mux = mux_q[31:0];
      `DTS_REG_MUX_HI:    rd_mux = {{(32-MUX_HI_W){1'b0}}, mux_q[`DTS_MUX_W-1:32]};
      `DTS_REG_THREE_BIT: rd_mux = {31'b0, three_bit_q};
      `DTS_REG_ERR:       rd_mux = {{(32-`DTS_NUM_CH){1'b0}}, err_q};
      default:            rd_mux = '0;
    endcase
  end

  // Held until the next read
  // Valid while ack is high
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      rdata_q <= '0;
    end else if (bus_req && !wb_we_i) begin
      rdata_q <= rd_mux;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////////////////////////

  assign wb_dat_o     = rdata_q;
  assign wb_ack_o     = ack_q;
  assign wb_err_o     = 1'b0;
  assign ctrl_word_o  = ctrl_q;
  assign ctrl_ready_o = ready_q;

  // Quasi-static levels straight from the bus domain
  assign shift_advance_o = delay_q.f.advance;
  assign shift_delay_o   = delay_q.f.delay;
  assign shift_rst_o     = delay_q.f.shift_rst;
  assign mux_control_o   = mux_q;
  assign is_three_bit_o  = three_bit_q;
  assign induce_error_o  = err_q;

endmodule

`default_nettype wire

// File: flist.f
+incdir+include
design/dts_regmap_pkg.sv
design/dts_status_pkg.sv
design/wb_dts_regs.sv
design/dts_ctrl_cdc.sv
design/dts_status_cdc.sv
design/wb_dts_attach.sv
bench/tb_clock_gen.sv
bench/tb_wb_dts_attach.sv

// File: include/dts_attach_consts.svh
`ifndef DTS_ATTACH_CONSTS_SVH
`define DTS_ATTACH_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// Deformatter geometry
//////////////////////////////////////////////////////////////////////

// One antenna worth of deformatter channels
`define DTS_NUM_CH 12

// Mux select, 4 bits per channel
`define DTS_MUX_W 48

//////////////////////////////////////////////////////////////////////
// Register map
//////////////////////////////////////////////////////////////////////

// Word offsets, as seen on the address select field
`define DTS_REG_CTRL      4'd0
`define DTS_REG_DELAY     4'd1
`define DTS_REG_MUX_LO    4'd2
`define DTS_REG_MUX_HI    4'd3
`define DTS_REG_THREE_BIT 4'd4
`define DTS_REG_ERR       4'd5

// Byte address bits that pick the register
`define DTS_ADR_LSB 2
`define DTS_ADR_MSB 5

// Flops per clock domain crossing
`define DTS_SYNC_STAGES 2

`endif
